// ==== design/img_pkg.sv ====
package img_pkg;

    // ====================
    // Image format
    // ====================
    localparam int header_word_count = 4;
    localparam int header_width = 64;
    localparam int buffer_depth = 256;

    // Top 7 pixel bits that classify a sample
    localparam logic [6:0] highlight_code = 7'h7f;
    localparam logic [6:0] shadow_code = 7'h00;

    localparam int unsigned fletcher_modulus = 65535;

    // ====================
    // Types
    // ====================
    typedef logic [11:0] pixel_t;
    typedef logic [15:0] word_t;
    typedef logic [header_width-1:0] header_t;
    typedef logic [$clog2(buffer_depth)-1:0] addr_t;
    typedef logic [$clog2(buffer_depth):0] word_count_t;
    typedef logic [17:0] stat_count_t;

    // Second sum in the upper half, first sum in the lower half
    typedef logic [31:0] checksum_t;

    typedef enum logic [2:0] {
        idle,
        clear,
        header,
        wait_fv_low,
        wait_fv_high,
        pixels,
        checksum_lo,
        checksum_hi
    } capture_state_t;

    typedef struct packed {
        logic   fv;
        logic   lv;
        pixel_t d;
    } pixel_bus_t;

    typedef struct packed {
        logic  valid;
        word_t data;
    } word_wr_t;

endpackage

// ==== design/fletcher_checksum.sv ====
module fletcher_checksum (
    input  logic                clk,
    input  logic                readout_rst,
    input  logic                clear,
    input  logic                en,
    input  img_pkg::word_t      data,
    output img_pkg::checksum_t  checksum
);
    logic [15:0] sum_a;
    logic [15:0] sum_b;
    logic [15:0] sum_a_next;
    img_pkg::word_t data_swapped;

    // Modular add where both operands are already below the modulus
    function automatic logic [15:0] mod_add(input logic [15:0] x, input logic [15:0] y);
        logic [16:0] s;
        s = {1'b0, x} + {1'b0, y};
        if (s >= 17'(img_pkg::fletcher_modulus)) begin
            s = s - 17'(img_pkg::fletcher_modulus);
        end
        return s[15:0];
    endfunction

    // Host reads the words little endian
    assign data_swapped = {data[7:0], data[15:8]};
    assign sum_a_next = mod_add(sum_a, data_swapped);

    always_ff @(posedge clk) begin
        if (!readout_rst || clear) begin
            sum_a <= '0;
            sum_b <= '0;
        end else if (en) begin
            sum_a <= sum_a_next;
            sum_b <= mod_add(sum_b, sum_a_next);
        end
    end

    assign checksum = {sum_b, sum_a};

    a_sums_reduced: assert property (@(posedge clk) disable iff (!readout_rst)
        (sum_a != 16'(img_pkg::fletcher_modulus)) && (sum_b != 16'(img_pkg::fletcher_modulus)));

endmodule

// ==== design/pixel_stats.sv ====
module pixel_stats (
    input  logic                  clk,
    input  logic                  readout_rst,
    input  logic                  clear,
    input  logic                  window,
    input  img_pkg::pixel_bus_t   pixel_bus,
    output img_pkg::stat_count_t  highlight_count,
    output img_pkg::stat_count_t  shadow_count
);
    logic [1:0] col_phase;
    logic [1:0] row_phase;
    logic lv_prev;
    logic sample_en;
    logic [6:0] sample_px;

    // ====================
    // 4x4 grid phase
    // ====================
    always_ff @(posedge clk) begin
        if (!readout_rst) begin
            col_phase <= '0;
            row_phase <= '0;
            lv_prev <= 1'b0;
        end else begin
            lv_prev <= pixel_bus.lv;
            if (!pixel_bus.lv) begin
                col_phase <= '0;
            end else begin
                col_phase <= col_phase + 1'b1;
            end
            // Row advances at the end of each line
            if (!pixel_bus.fv) begin
                row_phase <= '0;
            end else if (lv_prev && !pixel_bus.lv) begin
                row_phase <= row_phase + 1'b1;
            end
        end
    end

    // First pixel of every fourth column on every fourth line
    assign sample_en = window && pixel_bus.fv && pixel_bus.lv
        && (col_phase == 2'd0) && (row_phase == 2'd0);
    assign sample_px = pixel_bus.d[11:5];

    // ====================
    // Counters
    // ====================
    always_ff @(posedge clk) begin
        if (!readout_rst || clear) begin
            highlight_count <= '0;
            shadow_count <= '0;
        end else if (sample_en) begin
            if (sample_px == img_pkg::highlight_code) begin
                highlight_count <= highlight_count + 1'b1;
            end else if (sample_px == img_pkg::shadow_code) begin
                shadow_count <= shadow_count + 1'b1;
            end
        end
    end

    a_count_in_window: assert property (@(posedge clk) disable iff (!readout_rst)
        (!window && !clear) |=> ($stable(highlight_count) && $stable(shadow_count)));

endmodule

// ==== design/img_buffer.sv ====
module img_buffer (
    input  logic                  clk,
    input  logic                  readout_rst,
    input  logic                  clear,
    input  img_pkg::word_wr_t     wr,
    input  logic                  cmd_readout,
    input  logic                  capture_busy,
    output logic                  readout_busy,
    output logic                  readout_valid,
    input  logic                  readout_ready,
    output img_pkg::word_t        readout_data,
    output img_pkg::word_count_t  word_count
);
    img_pkg::word_t mem [img_pkg::buffer_depth];
    img_pkg::word_count_t wr_ptr;
    img_pkg::word_count_t rd_ptr;
    img_pkg::addr_t wr_addr;
    img_pkg::addr_t rd_addr;
    img_pkg::word_t mem_q;
    logic buffer_full;
    logic rd_start;
    logic rd_active;
    logic rd_last;
    logic mem_valid;
    logic out_take;
    logic issue;

    assign buffer_full = (wr_ptr == img_pkg::word_count_t'(img_pkg::buffer_depth));
    assign wr_addr = img_pkg::addr_t'(wr_ptr);
    assign rd_addr = img_pkg::addr_t'(rd_ptr);

    assign rd_start = cmd_readout && !capture_busy && !readout_busy;
    assign rd_last = rd_active && (rd_ptr == wr_ptr);

    // Output register can load when empty or when its word leaves
    assign out_take = !readout_valid || readout_ready;

    // A read is issued only if the memory stage has somewhere to go
    assign issue = (rd_start || rd_active) && (rd_ptr < wr_ptr) && (!mem_valid || out_take);

    assign readout_busy = rd_active || mem_valid || readout_valid;
    assign word_count = wr_ptr;

    // ====================
    // Memory
    // ====================
    always_ff @(posedge clk) begin
        if (wr.valid && !buffer_full) begin
            mem[wr_addr] <= wr.data;
        end
        if (issue) begin
            mem_q <= mem[rd_addr];
        end
    end

    always_ff @(posedge clk) begin
        if (out_take && mem_valid) begin
            readout_data <= mem_q;
        end
    end

    // ====================
    // Pointers and readout
    // ====================
    always_ff @(posedge clk) begin
        if (!readout_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            rd_active <= 1'b0;
            mem_valid <= 1'b0;
            readout_valid <= 1'b0;
        end else begin
            // Saturates at full, later words are dropped
            if (clear) begin
                wr_ptr <= '0;
            end else if (wr.valid && !buffer_full) begin
                wr_ptr <= wr_ptr + 1'b1;
            end

            if (rd_start) begin
                rd_active <= 1'b1;
            end else if (rd_last) begin
                rd_active <= 1'b0;
            end

            if (issue) begin
                rd_ptr <= rd_ptr + 1'b1;
            end else if (rd_last) begin
                rd_ptr <= '0;
            end

            if (issue) begin
                mem_valid <= 1'b1;
            end else if (out_take) begin
                mem_valid <= 1'b0;
            end

            if (out_take) begin
                readout_valid <= mem_valid;
            end
        end
    end

    a_hold_on_stall: assert property (@(posedge clk) disable iff (!readout_rst)
        (readout_valid && !readout_ready) |=> (readout_valid && $stable(readout_data)));

endmodule

// ==== design/frame_capture.sv ====
module frame_capture (
    input  logic                   clk,
    input  logic                   readout_rst,
    input  logic                   cmd_capture,
    input  img_pkg::header_t       cmd_header,
    input  img_pkg::pixel_t        img_d,
    input  logic                   img_fv,
    input  logic                   img_lv,
    input  logic                   readout_busy,
    input  img_pkg::checksum_t     checksum,
    output img_pkg::pixel_bus_t    pixel_bus,
    output logic                   pixel_window,
    output logic                   stats_clear,
    output logic                   sum_en,
    output img_pkg::word_t         sum_data,
    output logic                   sum_clear,
    output img_pkg::word_wr_t      wr,
    output logic                   buffer_clear,
    output logic                   capture_done,
    output logic                   capture_busy
);
    img_pkg::capture_state_t state;
    img_pkg::header_t header_q;
    logic [$clog2(img_pkg::header_word_count)-1:0] hdr_cnt;
    logic capture_start;

    // ====================
    // Sensor pin stage
    // ====================
    always_ff @(posedge clk) begin
        if (!readout_rst) begin
            pixel_bus <= '0;
        end else begin
            pixel_bus.fv <= img_fv;
            pixel_bus.lv <= img_lv;
            pixel_bus.d <= img_d;
        end
    end

    // Capture wins a tie with a readout command in the same cycle
    assign capture_start = cmd_capture && !readout_busy && (state == img_pkg::idle);
    assign capture_busy = (state != img_pkg::idle) || capture_start;

    // ====================
    // Capture FSM
    // ====================
    always_ff @(posedge clk) begin
        if (!readout_rst) begin
            state <= img_pkg::idle;
            hdr_cnt <= '0;
            capture_done <= 1'b0;
        end else begin
            capture_done <= (state == img_pkg::checksum_hi);
            case (state)
                img_pkg::idle: begin
                    if (capture_start) begin
                        state <= img_pkg::clear;
                    end
                end
                img_pkg::clear: begin
                    hdr_cnt <= '0;
                    state <= img_pkg::header;
                end
                img_pkg::header: begin
                    hdr_cnt <= hdr_cnt + 1'b1;
                    if (int'(hdr_cnt) == img_pkg::header_word_count - 1) begin
                        state <= img_pkg::wait_fv_low;
                    end
                end
                // Skip the rest of a frame that is already running
                img_pkg::wait_fv_low: begin
                    if (!pixel_bus.fv) begin
                        state <= img_pkg::wait_fv_high;
                    end
                end
                img_pkg::wait_fv_high: begin
                    if (pixel_bus.fv) begin
                        state <= img_pkg::pixels;
                    end
                end
                img_pkg::pixels: begin
                    if (!pixel_bus.fv) begin
                        state <= img_pkg::checksum_lo;
                    end
                end
                img_pkg::checksum_lo: state <= img_pkg::checksum_hi;
                img_pkg::checksum_hi: state <= img_pkg::idle;
                default: state <= img_pkg::idle;
            endcase
        end
    end

    // Header goes out most significant word first
    always_ff @(posedge clk) begin
        if (state == img_pkg::clear) begin
            header_q <= cmd_header;
        end else if (state == img_pkg::header) begin
            header_q <= header_q << $bits(img_pkg::word_t);
        end
    end

    // ====================
    // Word stream
    // ====================
    always_comb begin
        wr = '0;
        case (state)
            img_pkg::header: begin
                wr.valid = 1'b1;
                wr.data = header_q[img_pkg::header_width-1 -: 16];
            end
            img_pkg::pixels: begin
                // Little endian: low pixel byte first
                wr.valid = pixel_bus.lv;
                wr.data = {pixel_bus.d[7:0], 4'b0000, pixel_bus.d[11:8]};
            end
            img_pkg::checksum_lo: begin
                wr.valid = 1'b1;
                wr.data = {checksum[7:0], checksum[15:8]};
            end
            img_pkg::checksum_hi: begin
                wr.valid = 1'b1;
                wr.data = {checksum[23:16], checksum[31:24]};
            end
            default: wr = '0;
        endcase
    end

    // Checksum words themselves stay out of the sum
    assign sum_en = wr.valid && ((state == img_pkg::header) || (state == img_pkg::pixels));
    assign sum_data = wr.data;

    assign sum_clear = (state == img_pkg::clear);
    assign stats_clear = (state == img_pkg::clear);
    assign buffer_clear = (state == img_pkg::clear);
    assign pixel_window = (state == img_pkg::pixels);

    a_no_write_outside_frame: assert property (@(posedge clk) disable iff (!readout_rst)
        (state inside {img_pkg::idle, img_pkg::wait_fv_low, img_pkg::wait_fv_high})
        |-> !wr.valid);

endmodule

// ==== design/img_controller.sv ====
module img_controller (
    input  logic                  clk,
    input  logic                  readout_rst,
    input  logic                  cmd_capture,
    input  logic                  cmd_readout,
    input  img_pkg::header_t      cmd_header,
    input  img_pkg::pixel_t       img_d,
    input  logic                  img_fv,
    input  logic                  img_lv,
    output logic                  readout_valid,
    input  logic                  readout_ready,
    output img_pkg::word_t        readout_data,
    output logic                  status_capture_done,
    output img_pkg::word_count_t  status_word_count,
    output img_pkg::stat_count_t  status_highlight_count,
    output img_pkg::stat_count_t  status_shadow_count
);
    img_pkg::pixel_bus_t pixel_bus;
    img_pkg::word_t sum_data;
    img_pkg::checksum_t checksum;
    img_pkg::word_wr_t wr;
    logic pixel_window;
    logic stats_clear;
    logic sum_en;
    logic sum_clear;
    logic buffer_clear;
    logic capture_busy;
    logic readout_busy;

    // ====================
    // Capture side
    // ====================
    frame_capture u_frame_capture (
        .clk          (clk),
        .readout_rst  (readout_rst),
        .cmd_capture  (cmd_capture),
        .cmd_header   (cmd_header),
        .img_d        (img_d),
        .img_fv       (img_fv),
        .img_lv       (img_lv),
        .readout_busy (readout_busy),
        .checksum     (checksum),
        .pixel_bus    (pixel_bus),
        .pixel_window (pixel_window),
        .stats_clear  (stats_clear),
        .sum_en       (sum_en),
        .sum_data     (sum_data),
        .sum_clear    (sum_clear),
        .wr           (wr),
        .buffer_clear (buffer_clear),
        .capture_done (status_capture_done),
        .capture_busy (capture_busy)
    );

    fletcher_checksum u_fletcher_checksum (
        .clk         (clk),
        .readout_rst (readout_rst),
        .clear       (sum_clear),
        .en          (sum_en),
        .data        (sum_data),
        .checksum    (checksum)
    );

    pixel_stats u_pixel_stats (
        .clk             (clk),
        .readout_rst     (readout_rst),
        .clear           (stats_clear),
        .window          (pixel_window),
        .pixel_bus       (pixel_bus),
        .highlight_count (status_highlight_count),
        .shadow_count    (status_shadow_count)
    );

    // ====================
    // Buffer and readout
    // ====================
    img_buffer u_img_buffer (
        .clk           (clk),
        .readout_rst   (readout_rst),
        .clear         (buffer_clear),
        .wr            (wr),
        .cmd_readout   (cmd_readout),
        .capture_busy  (capture_busy),
        .readout_busy  (readout_busy),
        .readout_valid (readout_valid),
        .readout_ready (readout_ready),
        .readout_data  (readout_data),
        .word_count    (status_word_count)
    );

endmodule

// ==== tb/clk_gen.sv ====
module clk_gen (
    output logic clk
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int period_ns = 4;

    initial begin
        clk = 1'b0;
        forever begin
            #(period_ns / 2) clk = ~clk;
        end
    end

endmodule

// ==== tb/img_controller_tb.sv ====
module img_controller_tb;
    timeunit 1ns;
    timeprecision 100ps;

    // One row of the stimulus table
    typedef struct packed {
        img_pkg::header_t header;
        int               lines;
        int               line_pixels;
        int               gap;
        int               stall_pct;
        int               fill;
    } frame_entry_t;

    localparam int frame_total = 5;
    localparam int wait_limit = 400;

    logic clk;
    logic readout_rst;
    logic cmd_capture;
    logic cmd_readout;
    img_pkg::header_t cmd_header;
    img_pkg::pixel_t img_d;
    logic img_fv;
    logic img_lv;
    logic readout_valid;
    logic readout_ready;
    img_pkg::word_t readout_data;
    logic status_capture_done;
    img_pkg::word_count_t status_word_count;
    img_pkg::stat_count_t status_highlight_count;
    img_pkg::stat_count_t status_shadow_count;

    frame_entry_t frame_table [frame_total];
    img_pkg::word_t expected_words [$];
    integer seed;
    int errors;
    int timeouts;
    int exp_highlight;
    int exp_shadow;

    clk_gen u_clk_gen (.clk(clk));

    img_controller uut (
        .clk                    (clk),
        .readout_rst            (readout_rst),
        .cmd_capture            (cmd_capture),
        .cmd_readout            (cmd_readout),
        .cmd_header             (cmd_header),
        .img_d                  (img_d),
        .img_fv                 (img_fv),
        .img_lv                 (img_lv),
        .readout_valid          (readout_valid),
        .readout_ready          (readout_ready),
        .readout_data           (readout_data),
        .status_capture_done    (status_capture_done),
        .status_word_count      (status_word_count),
        .status_highlight_count (status_highlight_count),
        .status_shadow_count    (status_shadow_count)
    );

    // ====================
    // Helpers
    // ====================
    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        assert (got == exp) else begin
            errors++;
            $display("[FAIL] %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    function automatic img_pkg::word_t swap_bytes(input img_pkg::word_t w);
        return {w[7:0], w[15:8]};
    endfunction

    // Fill 0 random, 1 all ones, 2 all zeros, 3 ones/zeros/random mix
    task automatic load_table();
        frame_table[0] = '{64'h0123_4567_89ab_cdef, 3, 8, 2, 0, 0};
        frame_table[1] = '{64'hfeed_0001_a5a5_5a5a, 5, 9, 1, 30, 1};
        frame_table[2] = '{64'h0000_ffff_1234_8000, 6, 7, 3, 50, 2};
        frame_table[3] = '{64'h7e57_0bad_c0de_0042, 9, 12, 2, 70, 3};
        frame_table[4] = '{64'h1111_2222_3333_4444, 4, 16, 1, 25, 0};
    endtask

    // ====================
    // Capture and model
    // ====================
    task automatic capture_frame(input frame_entry_t e, input int idx);
        img_pkg::pixel_t px;
        int sum_a;
        int sum_b;
        int k;
        int cycles;
        logic done_seen;
        sum_a = 0;
        sum_b = 0;
        exp_highlight = 0;
        exp_shadow = 0;
        expected_words.delete();
        for (k = 0; k < img_pkg::header_word_count; k++) begin
            expected_words.push_back(e.header[img_pkg::header_width - 1 - 16 * k -: 16]);
        end

        @(posedge clk);
        cmd_capture <= 1'b1;
        cmd_header <= e.header;
        @(posedge clk);
        cmd_capture <= 1'b0;
        // Sensor stays idle until the header is out
        repeat (8) @(posedge clk);
        img_fv <= 1'b1;
        repeat (2) @(posedge clk);
        for (int r = 0; r < e.lines; r++) begin
            for (int c = 0; c < e.line_pixels; c++) begin
                k = r * e.line_pixels + c;
                case (e.fill)
                    1: px = 12'hfff;
                    2: px = 12'h000;
                    3: px = (k % 3 == 0) ? 12'hfff : (k % 3 == 1) ? 12'h000
                                                   : img_pkg::pixel_t'($random(seed));
                    default: px = img_pkg::pixel_t'($random(seed));
                endcase
                img_lv <= 1'b1;
                img_d <= px;
                expected_words.push_back(swap_bytes({4'h0, px}));
                // Sparse grid, every fourth pixel of every fourth line
                if ((r % 4 == 0) && (c % 4 == 0)) begin
                    if (px[11:5] == img_pkg::highlight_code) begin
                        exp_highlight++;
                    end else if (px[11:5] == img_pkg::shadow_code) begin
                        exp_shadow++;
                    end
                end
                @(posedge clk);
            end
            img_lv <= 1'b0;
            img_d <= '0;
            repeat (e.gap) @(posedge clk);
        end
        img_fv <= 1'b0;

        foreach (expected_words[i]) begin
            sum_a = (sum_a + int'(swap_bytes(expected_words[i]))) % img_pkg::fletcher_modulus;
            sum_b = (sum_b + sum_a) % img_pkg::fletcher_modulus;
        end
        expected_words.push_back(swap_bytes(img_pkg::word_t'(sum_a)));
        expected_words.push_back(swap_bytes(img_pkg::word_t'(sum_b)));

        cycles = 0;
        done_seen = 1'b0;
        while (!done_seen && cycles < wait_limit) begin
            @(negedge clk);
            done_seen = status_capture_done;
            cycles++;
        end
        if (!done_seen) begin
            $display("Timeout: frame %0d capture never signaled done", idx);
            timeouts++;
            return;
        end
        check_equal(status_word_count,
                    img_pkg::header_word_count + e.lines * e.line_pixels + 2, "word count");
        check_equal(status_highlight_count, exp_highlight, "highlight count");
        check_equal(status_shadow_count, exp_shadow, "shadow count");
        @(negedge clk);
        check_equal(status_capture_done, 1'b0, "capture_done one cycle later");
    endtask

    // ====================
    // Readout with stalls
    // ====================
    task automatic read_frame(input frame_entry_t e, input int idx);
        int got;
        int cycles;
        got = 0;
        cycles = 0;
        @(posedge clk);
        cmd_readout <= 1'b1;
        @(posedge clk);
        cmd_readout <= 1'b0;
        while (got < expected_words.size() && cycles < wait_limit * 4) begin
            readout_ready <= (($unsigned($random(seed)) % 100) >= e.stall_pct);
            @(negedge clk);
            if (readout_valid && readout_ready) begin
                check_equal(readout_data, expected_words[got],
                            $sformatf("frame %0d word %0d", idx, got));
                got++;
            end
            @(posedge clk);
            cycles++;
        end
        if (got < expected_words.size()) begin
            $display("Timeout: frame %0d readout stopped after %0d of %0d words",
                     idx, got, expected_words.size());
            timeouts++;
            return;
        end
        // No extra word after the last transfer
        readout_ready <= 1'b1;
        repeat (4) begin
            @(negedge clk);
            check_equal(readout_valid, 1'b0, $sformatf("frame %0d valid after end", idx));
        end
    endtask

    initial begin
        seed = 2;
        errors = 0;
        timeouts = 0;
        readout_rst = 1'b0;
        cmd_capture = 1'b0;
        cmd_readout = 1'b0;
        cmd_header = '0;
        img_d = '0;
        img_fv = 1'b0;
        img_lv = 1'b0;
        readout_ready = 1'b0;
        load_table();

        repeat (5) @(posedge clk);
        readout_rst <= 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_equal(status_capture_done, 1'b0, "capture_done after reset");
            check_equal(readout_valid, 1'b0, "readout_valid after reset");
            check_equal(status_word_count, 0, "word count after reset");
            check_equal(status_highlight_count, 0, "highlight count after reset");
            check_equal(status_shadow_count, 0, "shadow count after reset");
        end

        for (int i = 0; i < frame_total; i++) begin
            capture_frame(frame_table[i], i);
            if (timeouts == 0) begin
                read_frame(frame_table[i], i);
            end
            if (timeouts != 0) begin
                break;
            end
        end

        $display("Checks finished with %0d errors and %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== all.f ====
design/img_pkg.sv
design/fletcher_checksum.sv
design/pixel_stats.sv
design/img_buffer.sv
design/frame_capture.sv
design/img_controller.sv
tb/clk_gen.sv
tb/img_controller_tb.sv

// ==== Bender.yml ====
package:
  name: img_controller

sources:
  - design/img_pkg.sv
  - design/fletcher_checksum.sv
  - design/pixel_stats.sv
  - design/img_buffer.sv
  - design/frame_capture.sv
  - design/img_controller.sv
  - target: simulation
    files:
      - tb/clk_gen.sv
      - tb/img_controller_tb.sv
